//--- design/simd_settings.svh
// ----------------------------
// Shared sizing macros for the SIMD wrapper
// Lane count and lane word widths
// Tag and option pointer widths
// Result and tag FIFO depths and thresholds
// Option table depth
// ----------------------------
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// Lanes and lane words
`define SIMD_NUM_LANES             4
`define SIMD_LANE_WIDTH            32
`define SIMD_CNTL_WIDTH            2

// Tag side
`define SIMD_TAG_WIDTH             8
`define SIMD_OPT_PTR_WIDTH         4
`define SIMD_OPT_TABLE_DEPTH       16

// Queue sizing with ready dropping at the threshold
`define SIMD_RESULT_FIFO_DEPTH     4
`define SIMD_RESULT_FIFO_THRESHOLD 3
`define SIMD_TAG_FIFO_DEPTH        4
`define SIMD_TAG_FIFO_THRESHOLD    3

`endif

//--- design/simd_pkg.sv
// ----------------------------
// Types shared by the SIMD wrapper
// Lane, tag and option table types
// ALU operation and sequencer state enums
// ----------------------------
`include "simd_settings.svh"

package simd_pkg;

  typedef logic [`SIMD_LANE_WIDTH-1:0]    lane_data_t;
  typedef logic [`SIMD_CNTL_WIDTH-1:0]    lane_cntl_t;
  typedef logic [`SIMD_NUM_LANES-1:0]     lane_mask_t;
  // Active-lane count, 0 to 4
  typedef logic [2:0]                     num_lanes_t;
  typedef logic [`SIMD_TAG_WIDTH-1:0]     tag_t;
  typedef logic [`SIMD_OPT_PTR_WIDTH-1:0] opt_ptr_t;

  typedef enum logic [1:0] {
    OP_PASS       = 2'd0,
    OP_ADD_SCALAR = 2'd1,
    OP_MAX_SCALAR = 2'd2,
    OP_RELU       = 2'd3
  } simd_op_e;

  // Enable clear means results bypass the ALU
  typedef struct packed {
    logic     enable;
    simd_op_e op;
  } option_entry_t;

  typedef struct packed {
    tag_t       tag;
    opt_ptr_t   opt_ptr;
    num_lanes_t num_lanes;
  } tag_entry_t;

  typedef enum logic [2:0] {
    IDLE          = 3'd0,
    CHECK_ENABLE  = 3'd1,
    WAIT_START    = 3'd2,
    WAIT_DONE     = 3'd3,
    SEND          = 3'd4,
    WAIT_COMPLETE = 3'd5,
    WAIT_RELEASE  = 3'd6,
    FINISH        = 3'd7
  } upstream_state_e;

endpackage

//--- design/lane_result_if.sv
// ----------------------------
// Lane result bundle
// FIFO heads toward sequencer and ALU
// ALU results back to the sequencer
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

interface lane_result_if;

  // Queue side
  simd_pkg::lane_mask_t avail;
  simd_pkg::lane_mask_t pop;
  simd_pkg::lane_cntl_t cntl [`SIMD_NUM_LANES];
  simd_pkg::lane_data_t data [`SIMD_NUM_LANES];

  // ALU results held stable until the next start
  simd_pkg::lane_cntl_t alu_cntl [`SIMD_NUM_LANES];
  simd_pkg::lane_data_t alu_data [`SIMD_NUM_LANES];
  simd_pkg::lane_mask_t alu_valid;

  modport buffer (output avail, cntl, data, input pop);

  modport sequencer (input avail, cntl, data, alu_cntl, alu_data, alu_valid,
                     output pop);

  // avail is sampled at start to mark which lanes the ALU worked on
  modport alu (input avail, cntl, data, output alu_cntl, alu_data, alu_valid);

endinterface

//--- design/sync_fifo.sv
// ----------------------------
// Synchronous FIFO, first word fall through
// Head visible whenever not_empty is high
// almost_full at THRESHOLD entries
// ----------------------------
`timescale 1ns/100ps

module sync_fifo #(
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = 3,
  parameter int WIDTH     = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             write,
  input  logic [WIDTH-1:0] write_data,
  input  logic             read,
  output logic [WIDTH-1:0] read_data,
  output logic             not_empty,
  output logic             almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_write;
  logic             do_read;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(DEPTH));
  assign not_empty   = (count != '0);
  assign almost_full = (count >= CNT_W'(THRESHOLD));
  assign do_write    = write && !full;
  assign do_read     = read && not_empty;
  assign read_data   = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr] <= write_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_write)
      begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read)
      begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_write && !do_read)
      begin
        count <= count + 1'b1;
      end
      else if (do_read && !do_write)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Producer must respect almost_full, consumer must respect not_empty
  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n) write |-> !full)
    else $error("sync_fifo: write while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n) read |-> not_empty)
    else $error("sync_fifo: read while empty");

endmodule

//--- design/lane_result_buffer.sv
// ----------------------------
// Per-lane result queues
// One FIFO per lane holding cntl and data
// Ready per lane from its almost-full flag
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module lane_result_buffer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  simd_pkg::lane_mask_t result_valid,
  input  simd_pkg::lane_cntl_t result_cntl [`SIMD_NUM_LANES],
  input  simd_pkg::lane_data_t result_data [`SIMD_NUM_LANES],
  output simd_pkg::lane_mask_t result_ready,
  lane_result_if.buffer        lanes
);

  localparam int ENTRY_W = `SIMD_CNTL_WIDTH + `SIMD_LANE_WIDTH;

  // Lanes queue independently so the next stream can land early
  for (genvar i = 0; i < `SIMD_NUM_LANES; i++)
  begin : g_lane
    logic [ENTRY_W-1:0] head;
    logic               head_valid;
    logic               almost_full;

    sync_fifo #(
      .DEPTH     (`SIMD_RESULT_FIFO_DEPTH),
      .THRESHOLD (`SIMD_RESULT_FIFO_THRESHOLD),
      .WIDTH     (ENTRY_W)
    ) u_fifo (
      .clk         (clk),
      .arst_n      (arst_n),
      .write       (result_valid[i]),
      .write_data  ({result_cntl[i], result_data[i]}),
      .read        (lanes.pop[i]),
      .read_data   (head),
      .not_empty   (head_valid),
      .almost_full (almost_full)
    );

    assign result_ready[i] = ~almost_full;
    assign lanes.avail[i]  = head_valid;
    // Control bits sit above the lane word
    assign lanes.cntl[i]   = head[ENTRY_W-1 -: `SIMD_CNTL_WIDTH];
    assign lanes.data[i]   = head[`SIMD_LANE_WIDTH-1:0];
  end

endmodule

//--- design/option_table.sv
// ----------------------------
// Option table
// Register array with one write port
// Combinational read at the head tag pointer
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module option_table (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    wr_en,
  input  simd_pkg::opt_ptr_t      wr_addr,
  input  simd_pkg::option_entry_t wr_data,
  input  simd_pkg::opt_ptr_t      rd_addr,
  output simd_pkg::option_entry_t rd_data
);

  simd_pkg::option_entry_t entries [`SIMD_OPT_TABLE_DEPTH];

  // All entries come up disabled
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `SIMD_OPT_TABLE_DEPTH; i++)
      begin
        entries[i] <= '{enable: 1'b0, op: simd_pkg::OP_PASS};
      end
    end
    else if (wr_en)
    begin
      entries[wr_addr] <= wr_data;
    end
  end

  assign rd_data = entries[rd_addr];

endmodule

//--- design/simd_lane_alu.sv
// ----------------------------
// Lane ALU
// One scalar operation applied to every lane
// processing then done, one cycle each
// Results held until the next start
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module simd_lane_alu (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  simd_pkg::simd_op_e   op,
  input  simd_pkg::lane_data_t scalar_operand,
  output logic                 processing,
  output logic                 done,
  lane_result_if.alu           lanes
);

  // Lane data is treated as signed
  function automatic simd_pkg::lane_data_t lane_op(
    simd_pkg::simd_op_e   op_sel,
    simd_pkg::lane_data_t d,
    simd_pkg::lane_data_t s
  );
    simd_pkg::lane_data_t r;
    case (op_sel)
      simd_pkg::OP_ADD_SCALAR: r = d + s;
      simd_pkg::OP_MAX_SCALAR: r = ($signed(d) > $signed(s)) ? d : s;
      simd_pkg::OP_RELU:       r = d[`SIMD_LANE_WIDTH-1] ? '0 : d;
      default:                 r = d;
    endcase
    return r;
  endfunction

  // ----------------------------
  // Sequencing
  // ----------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      processing      <= 1'b0;
      done            <= 1'b0;
      lanes.alu_valid <= '0;
    end
    else
    begin
      processing <= start;
      done       <= processing;
      if (start)
      begin
        lanes.alu_valid <= lanes.avail;
      end
    end
  end

  // Results land while processing is high
  always_ff @(posedge clk)
  begin
    if (processing)
    begin
      for (int i = 0; i < `SIMD_NUM_LANES; i++)
      begin
        lanes.alu_data[i] <= lane_op(op, lanes.data[i], scalar_operand);
        lanes.alu_cntl[i] <= lanes.cntl[i];
      end
    end
  end

  // Sequencer must not restart a busy ALU
  a_start_when_idle : assert property (@(posedge clk) disable iff (!arst_n)
    start |-> !(processing || done))
    else $error("simd_lane_alu: start while busy");

endmodule

//--- design/upstream_sequencer.sv
// ----------------------------
// Upstream sequencer
// Tag FIFO and registered tag_ready
// Transfer FSM with ALU or bypass data
// Registered upstream outputs
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module upstream_sequencer (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    tag_write,
  input  simd_pkg::tag_entry_t    tag_in,
  output logic                    tag_ready,
  input  simd_pkg::lane_mask_t    lane_mask,
  input  logic                    up_ready,
  input  logic                    up_complete,
  output simd_pkg::opt_ptr_t      opt_addr,
  input  simd_pkg::option_entry_t opt_entry,
  output logic                    alu_start,
  input  logic                    alu_done,
  lane_result_if.sequencer        lanes,
  output simd_pkg::lane_mask_t    up_valid,
  output simd_pkg::tag_t          up_tag,
  output simd_pkg::num_lanes_t    up_num_lanes,
  output simd_pkg::lane_cntl_t    up_cntl [`SIMD_NUM_LANES],
  output simd_pkg::lane_data_t    up_data [`SIMD_NUM_LANES]
);

  simd_pkg::upstream_state_e state;
  simd_pkg::upstream_state_e state_next;
  simd_pkg::tag_entry_t      head;
  simd_pkg::lane_mask_t      active_mask;
  simd_pkg::lane_cntl_t      send_cntl [`SIMD_NUM_LANES];
  simd_pkg::lane_data_t      send_data [`SIMD_NUM_LANES];
  logic                      tag_avail;
  logic                      tag_almost_full;
  logic                      lanes_ready;
  logic                      send;
  logic                      use_alu;

  // ----------------------------
  // Tag queue
  // ----------------------------
  sync_fifo #(
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD),
    .WIDTH     ($bits(simd_pkg::tag_entry_t))
  ) u_tag_fifo (
    .clk         (clk),
    .arst_n      (arst_n),
    .write       (tag_write),
    .write_data  (tag_in),
    .read        (send),
    .read_data   (head),
    .not_empty   (tag_avail),
    .almost_full (tag_almost_full)
  );

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tag_ready <= 1'b0;
    end
    else
    begin
      tag_ready <= ~tag_almost_full;
    end
  end

  // Masked-off lanes need no data
  assign lanes_ready = &(lanes.avail | ~lane_mask);
  assign opt_addr    = head.opt_ptr;
  assign send        = (state == simd_pkg::SEND);
  assign alu_start   = (state == simd_pkg::WAIT_START);
  assign lanes.pop   = send ? lanes.avail : '0;

  // ----------------------------
  // Transfer FSM
  // ----------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      simd_pkg::IDLE:
        if (tag_avail && up_ready && lanes_ready)
        begin
          state_next = simd_pkg::CHECK_ENABLE;
        end
      simd_pkg::CHECK_ENABLE:
        state_next = opt_entry.enable ? simd_pkg::WAIT_START : simd_pkg::SEND;
      simd_pkg::WAIT_START:
        state_next = simd_pkg::WAIT_DONE;
      simd_pkg::WAIT_DONE:
        if (alu_done)
        begin
          state_next = simd_pkg::SEND;
        end
      simd_pkg::SEND:
        state_next = simd_pkg::WAIT_COMPLETE;
      simd_pkg::WAIT_COMPLETE:
        if (up_complete)
        begin
          state_next = simd_pkg::WAIT_RELEASE;
        end
      simd_pkg::WAIT_RELEASE:
        if (!up_complete)
        begin
          state_next = simd_pkg::FINISH;
        end
      default:
        state_next = simd_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= simd_pkg::IDLE;
      use_alu <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // Table may be rewritten mid-transfer, so hold the choice
      if (state == simd_pkg::CHECK_ENABLE)
      begin
        use_alu <= opt_entry.enable;
      end
    end
  end

  // Lane mask from the tag's lane count, plus ALU or raw lane data
  always_comb
  begin
    for (int i = 0; i < `SIMD_NUM_LANES; i++)
    begin
      active_mask[i] = (i < int'(head.num_lanes));
      if (use_alu && lanes.alu_valid[i])
      begin
        send_cntl[i] = lanes.alu_cntl[i];
        send_data[i] = lanes.alu_data[i];
      end
      else
      begin
        send_cntl[i] = lanes.cntl[i];
        send_data[i] = lanes.data[i];
      end
    end
  end

  // ----------------------------
  // Upstream output registers
  // ----------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_valid     <= '0;
      up_tag       <= '0;
      up_num_lanes <= '0;
      for (int i = 0; i < `SIMD_NUM_LANES; i++)
      begin
        up_cntl[i] <= '0;
        up_data[i] <= '0;
      end
    end
    else
    begin
      up_valid <= send ? active_mask : '0;
      if (send)
      begin
        up_tag       <= head.tag;
        up_num_lanes <= head.num_lanes;
        for (int i = 0; i < `SIMD_NUM_LANES; i++)
        begin
          up_cntl[i] <= send_cntl[i];
          up_data[i] <= send_data[i];
        end
      end
    end
  end

  // One transfer per complete handshake, so valid never repeats
  a_valid_pulse : assert property (@(posedge clk) disable iff (!arst_n)
    (up_valid != '0) |=> (up_valid == '0))
    else $error("upstream_sequencer: up_valid held two cycles");

endmodule

//--- design/simd_wrapper.sv
// ----------------------------
// SIMD processing element wrapper
// Input registers for tag, config and upstream status
// Result queues, option table, lane ALU, sequencer
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module simd_wrapper (
  input  logic                    clk,
  input  logic                    arst_n,
  // Configuration
  input  simd_pkg::lane_data_t    scalar_operand,
  input  simd_pkg::lane_mask_t    lane_mask,
  // Tag input
  input  logic                    tag_valid,
  input  simd_pkg::tag_t          tag,
  input  simd_pkg::opt_ptr_t      tag_opt_ptr,
  input  simd_pkg::num_lanes_t    tag_num_lanes,
  output logic                    tag_ready,
  // Streaming results
  input  simd_pkg::lane_mask_t    result_valid,
  input  simd_pkg::lane_cntl_t    result_cntl [`SIMD_NUM_LANES],
  input  simd_pkg::lane_data_t    result_data [`SIMD_NUM_LANES],
  output simd_pkg::lane_mask_t    result_ready,
  // Upstream
  output simd_pkg::lane_mask_t    up_valid,
  output simd_pkg::tag_t          up_tag,
  output simd_pkg::num_lanes_t    up_num_lanes,
  output simd_pkg::lane_cntl_t    up_cntl [`SIMD_NUM_LANES],
  output simd_pkg::lane_data_t    up_data [`SIMD_NUM_LANES],
  input  logic                    up_ready,
  input  logic                    up_complete,
  // Option table write
  input  logic                    opt_wr_en,
  input  simd_pkg::opt_ptr_t      opt_wr_addr,
  input  simd_pkg::option_entry_t opt_wr_data
);

  logic                    tag_valid_q;
  logic                    up_ready_q;
  logic                    up_complete_q;
  simd_pkg::lane_mask_t    lane_mask_q;
  simd_pkg::lane_data_t    scalar_q;
  simd_pkg::tag_entry_t    tag_entry_q;
  simd_pkg::opt_ptr_t      opt_addr;
  simd_pkg::option_entry_t opt_entry;
  logic                    alu_start;
  logic                    alu_done;

  lane_result_if lanes ();

  // ----------------------------
  // Input registers
  // ----------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tag_valid_q   <= 1'b0;
      up_ready_q    <= 1'b0;
      up_complete_q <= 1'b0;
      lane_mask_q   <= '0;
    end
    else
    begin
      tag_valid_q   <= tag_valid;
      up_ready_q    <= up_ready;
      up_complete_q <= up_complete;
      lane_mask_q   <= lane_mask;
    end
  end

  always_ff @(posedge clk)
  begin
    scalar_q    <= scalar_operand;
    tag_entry_q <= '{tag: tag, opt_ptr: tag_opt_ptr, num_lanes: tag_num_lanes};
  end

  // ----------------------------
  // Blocks
  // ----------------------------
  lane_result_buffer u_result_buffer (
    .clk          (clk),
    .arst_n       (arst_n),
    .result_valid (result_valid),
    .result_cntl  (result_cntl),
    .result_data  (result_data),
    .result_ready (result_ready),
    .lanes        (lanes.buffer)
  );

  option_table u_option_table (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (opt_wr_en),
    .wr_addr (opt_wr_addr),
    .wr_data (opt_wr_data),
    .rd_addr (opt_addr),
    .rd_data (opt_entry)
  );

  // Head tag stays queued during processing, so op is stable
  simd_lane_alu u_lane_alu (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (alu_start),
    .op             (opt_entry.op),
    .scalar_operand (scalar_q),
    .processing     (),
    .done           (alu_done),
    .lanes          (lanes.alu)
  );

  upstream_sequencer u_sequencer (
    .clk          (clk),
    .arst_n       (arst_n),
    .tag_write    (tag_valid_q),
    .tag_in       (tag_entry_q),
    .tag_ready    (tag_ready),
    .lane_mask    (lane_mask_q),
    .up_ready     (up_ready_q),
    .up_complete  (up_complete_q),
    .opt_addr     (opt_addr),
    .opt_entry    (opt_entry),
    .alu_start    (alu_start),
    .alu_done     (alu_done),
    .lanes        (lanes.sequencer),
    .up_valid     (up_valid),
    .up_tag       (up_tag),
    .up_num_lanes (up_num_lanes),
    .up_cntl      (up_cntl),
    .up_data      (up_data)
  );

endmodule

//--- sim/tb_simd_wrapper.sv
// ----------------------------
// Testbench for the SIMD wrapper
// Clock, reset and option table setup
// Tag and lane result stimulus
// Expected-transfer queue and upstream responder
// Checking assertions
// ----------------------------
`timescale 1ns/100ps
`include "simd_settings.svh"

module tb_simd_wrapper;

  localparam int NL            = `SIMD_NUM_LANES;
  localparam int NUM_TRANSFERS = 21;
  localparam int CYCLE_LIMIT   = 40 * NUM_TRANSFERS + 200;

  typedef struct packed {
    simd_pkg::tag_t                              tag;
    simd_pkg::num_lanes_t                        num;
    logic [NL-1:0][`SIMD_CNTL_WIDTH-1:0]         cntl;
    logic [NL-1:0][`SIMD_LANE_WIDTH-1:0]         data;
  } xfer_t;

  logic                    clk = 1'b0;
  logic                    arst_n;
  simd_pkg::lane_data_t    scalar_operand;
  simd_pkg::lane_mask_t    lane_mask;
  logic                    tag_valid;
  simd_pkg::tag_t          tag;
  simd_pkg::opt_ptr_t      tag_opt_ptr;
  simd_pkg::num_lanes_t    tag_num_lanes;
  logic                    tag_ready;
  simd_pkg::lane_mask_t    result_valid;
  simd_pkg::lane_cntl_t    result_cntl [NL];
  simd_pkg::lane_data_t    result_data [NL];
  simd_pkg::lane_mask_t    result_ready;
  simd_pkg::lane_mask_t    up_valid;
  simd_pkg::tag_t          up_tag;
  simd_pkg::num_lanes_t    up_num_lanes;
  simd_pkg::lane_cntl_t    up_cntl [NL];
  simd_pkg::lane_data_t    up_data [NL];
  logic                    up_ready;
  logic                    up_complete;
  logic                    opt_wr_en;
  simd_pkg::opt_ptr_t      opt_wr_addr;
  simd_pkg::option_entry_t opt_wr_data;

  // Model state
  xfer_t              exp_q [$];
  logic               opt_en [`SIMD_OPT_TABLE_DEPTH];
  simd_pkg::simd_op_e opt_op [`SIMD_OPT_TABLE_DEPTH];
  simd_pkg::tag_t     last_sent_tag;
  simd_pkg::tag_t     last_up_tag;
  string              test_name;
  int                 test_count;
  int                 test_errs;
  int                 check_count;
  int                 err_count;
  int                 sent_count;
  int                 done_count;
  int                 events;
  int                 cycle_count;
  int                 cmpl_timer;
  logic               cmpl_busy;
  logic               hold_complete;
  logic               blocked;

  simd_wrapper UUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .scalar_operand (scalar_operand),
    .lane_mask      (lane_mask),
    .tag_valid      (tag_valid),
    .tag            (tag),
    .tag_opt_ptr    (tag_opt_ptr),
    .tag_num_lanes  (tag_num_lanes),
    .tag_ready      (tag_ready),
    .result_valid   (result_valid),
    .result_cntl    (result_cntl),
    .result_data    (result_data),
    .result_ready   (result_ready),
    .up_valid       (up_valid),
    .up_tag         (up_tag),
    .up_num_lanes   (up_num_lanes),
    .up_cntl        (up_cntl),
    .up_data        (up_data),
    .up_ready       (up_ready),
    .up_complete    (up_complete),
    .opt_wr_en      (opt_wr_en),
    .opt_wr_addr    (opt_wr_addr),
    .opt_wr_data    (opt_wr_data)
  );

  always #50 clk = ~clk;

  // Lane rule with signed data and operand
  function automatic simd_pkg::lane_data_t expect_lane(input logic en,
    input simd_pkg::simd_op_e op, input simd_pkg::lane_data_t d,
    input simd_pkg::lane_data_t s);
    int sd;
    int ss;
    sd = d;
    ss = s;
    if (!en)
      return d;
    case (op)
      simd_pkg::OP_ADD_SCALAR: return simd_pkg::lane_data_t'(sd + ss);
      simd_pkg::OP_MAX_SCALAR: return (sd >= ss) ? d : s;
      simd_pkg::OP_RELU:       return (sd < 0) ? '0 : d;
      default:                 return d;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
    input logic [31:0] actual);
    check_count++;
    assert (expected === actual)
    else
    begin
      err_count++;
      test_errs++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
    test_count++;
  endtask

  task automatic end_test();
    $display("test %s: done, %0d failed checks", test_name, test_errs);
  endtask

  task automatic write_option(input int ptr, input logic en, input simd_pkg::simd_op_e op);
    @(posedge clk);
    opt_wr_en   <= 1'b1;
    opt_wr_addr <= simd_pkg::opt_ptr_t'(ptr);
    opt_wr_data <= '{enable: en, op: op};
    opt_en[ptr] = en;
    opt_op[ptr] = op;
    @(posedge clk);
    opt_wr_en   <= 1'b0;
  endtask

  // One tag plus one word per lane, after both sides show ready
  task automatic send_transfer(input int num, input int ptr);
    xfer_t                e;
    simd_pkg::tag_t       t;
    simd_pkg::lane_data_t d;
    simd_pkg::lane_cntl_t c;
    do
      t = simd_pkg::tag_t'($urandom);
    while (t == '0 || t == last_sent_tag);
    last_sent_tag = t;
    @(posedge clk);
    while (!(tag_ready && (result_ready == '1)))
      @(posedge clk);
    e.tag = t;
    e.num = simd_pkg::num_lanes_t'(num);
    tag_valid     <= 1'b1;
    tag           <= t;
    tag_opt_ptr   <= simd_pkg::opt_ptr_t'(ptr);
    tag_num_lanes <= simd_pkg::num_lanes_t'(num);
    result_valid  <= '1;
    for (int i = 0; i < NL; i++)
    begin
      d = $urandom;
      c = simd_pkg::lane_cntl_t'($urandom);
      result_data[i] <= d;
      result_cntl[i] <= c;
      e.cntl[i] = c;
      e.data[i] = expect_lane(opt_en[ptr], opt_op[ptr], d, scalar_operand);
    end
    exp_q.push_back(e);
    sent_count++;
    @(posedge clk);
    tag_valid    <= 1'b0;
    result_valid <= '0;
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_drain();
    while (done_count != sent_count)
      @(posedge clk);
  endtask

  task automatic check_transfer();
    xfer_t                e;
    simd_pkg::lane_mask_t exp_mask;
    if (exp_q.size() == 0)
    begin
      err_count++;
      test_errs++;
      $display("ERROR %s: transfer with tag %h arrived while none was expected",
               test_name, up_tag);
    end
    else
    begin
      e = exp_q.pop_front();
      exp_mask = simd_pkg::lane_mask_t'((5'd1 << e.num) - 5'd1);
      check_value("up_valid", exp_mask, up_valid);
      check_value("up_tag", e.tag, up_tag);
      check_value("up_num_lanes", e.num, up_num_lanes);
      for (int i = 0; i < NL; i++)
      begin
        if (exp_mask[i])
        begin
          check_value($sformatf("up_data[%0d]", i), e.data[i], up_data[i]);
          check_value($sformatf("up_cntl[%0d]", i), e.cntl[i], up_cntl[i]);
        end
      end
    end
  endtask

  // ----------------------------
  // Upstream responder
  // ----------------------------
  // Each transfer is checked and then answered with an up_complete pulse
  // A zero-lane transfer shows only as a new up_tag
  always @(posedge clk)
  begin
    if (arst_n)
    begin
      if ((up_valid != '0) || (up_tag != last_up_tag))
      begin
        events     <= events + 1;
        cmpl_busy  <= 1'b1;
        cmpl_timer <= 0;
        check_transfer();
      end
      else if (cmpl_busy)
      begin
        if (cmpl_timer == 2)
          up_complete <= 1'b1;
        if (cmpl_timer < 5)
          cmpl_timer <= cmpl_timer + 1;
        else if (!hold_complete)
        begin
          up_complete <= 1'b0;
          cmpl_busy   <= 1'b0;
          cmpl_timer  <= 0;
          done_count  <= done_count + 1;
        end
      end
    end
    last_up_tag = up_tag;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles, test %s never finished", cycle_count, test_name);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ----------------------------
  // Assertions
  // ----------------------------
  a_reset_quiet : assert property (@(posedge clk)
    !arst_n |-> (up_valid == '0 && result_ready == '1))
  else
  begin
    err_count++;
    test_errs++;
    $display("ERROR %s: up_valid or result_ready wrong during reset", test_name);
  end

  a_blocked_quiet : assert property (@(posedge clk) disable iff (!arst_n)
    blocked |-> (up_valid == '0))
  else
  begin
    err_count++;
    test_errs++;
    $display("ERROR %s: transfer came out while up_ready was low", test_name);
  end

  a_complete_quiet : assert property (@(posedge clk) disable iff (!arst_n)
    up_complete |-> (up_valid == '0))
  else
  begin
    err_count++;
    test_errs++;
    $display("ERROR %s: transfer came out while up_complete was high", test_name);
  end

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial
  begin
    int    ev0;
    string op_names [4];
    op_names = '{"op_pass", "op_add_scalar", "op_max_scalar", "op_relu"};
    void'($urandom(36518));
    arst_n         <= 1'b0;
    scalar_operand = '0;
    lane_mask      = '1;
    tag_valid      = 1'b0;
    tag            = '0;
    tag_opt_ptr    = '0;
    tag_num_lanes  = '0;
    result_valid   = '0;
    up_ready       = 1'b1;
    up_complete    = 1'b0;
    opt_wr_en      = 1'b0;
    opt_wr_addr    = '0;
    opt_wr_data    = '0;
    hold_complete  = 1'b0;
    blocked        = 1'b0;
    cmpl_busy      = 1'b0;
    cmpl_timer     = 0;
    last_sent_tag  = '0;
    last_up_tag    = '0;
    for (int i = 0; i < NL; i++)
    begin
      result_cntl[i] = '0;
      result_data[i] = '0;
    end
    for (int i = 0; i < `SIMD_OPT_TABLE_DEPTH; i++)
    begin
      opt_en[i] = 1'b0;
      opt_op[i] = simd_pkg::OP_PASS;
    end

    begin_test("reset");
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_value("up_valid", 0, up_valid);
    check_value("result_ready", 4'hf, result_ready);
    check_value("tag_ready first cycle", 0, tag_ready);
    @(posedge clk);
    check_value("tag_ready", 1, tag_ready);
    end_test();

    // Entries 0 to 3 run each op, 4 to 7 hold the same ops disabled
    for (int k = 0; k < 4; k++)
    begin
      write_option(k, 1'b1, simd_pkg::simd_op_e'(k));
      write_option(k + 4, 1'b0, simd_pkg::simd_op_e'(k));
    end

    for (int k = 0; k < 4; k++)
    begin
      begin_test(op_names[k]);
      scalar_operand <= $urandom;
      repeat (2) send_transfer(4, k);
      wait_drain();
      end_test();
    end

    begin_test("bypass");
    scalar_operand <= $urandom;
    send_transfer(4, 5);
    send_transfer(4, 7);
    send_transfer(4, 15);
    wait_drain();
    end_test();

    begin_test("lane_count");
    for (int k = 0; k <= 4; k++)
      send_transfer(k, $urandom_range(3));
    wait_drain();
    end_test();

    begin_test("back_pressure");
    up_ready <= 1'b0;
    blocked  <= 1'b1;
    ev0 = events;
    repeat (3) send_transfer(4, $urandom_range(3));
    repeat (10) @(posedge clk);
    check_value("result_ready", 0, result_ready);
    check_value("tag_ready", 0, tag_ready);
    check_value("transfers while blocked", ev0, events);
    blocked  <= 1'b0;
    up_ready <= 1'b1;
    wait_drain();
    check_value("transfers after release", ev0 + 3, events);
    end_test();

    begin_test("complete_hold");
    hold_complete <= 1'b1;
    ev0 = events;
    send_transfer(4, $urandom_range(3));
    while (events == ev0)
      @(posedge clk);
    send_transfer(4, 6);
    repeat (30) @(posedge clk);
    check_value("transfers while complete high", ev0 + 1, events);
    hold_complete <= 1'b0;
    wait_drain();
    check_value("transfers after release", ev0 + 2, events);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d failures", test_count, check_count,
             err_count);
    if (err_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/simd_pkg.sv
design/lane_result_if.sv
design/sync_fifo.sv
design/lane_result_buffer.sv
design/option_table.sv
design/simd_lane_alu.sv
design/upstream_sequencer.sv
design/simd_wrapper.sv
sim/tb_simd_wrapper.sv

//--- Bender.yml
package:
  name: simd_wrapper

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/simd_pkg.sv
      - design/lane_result_if.sv
      - design/sync_fifo.sv
      - design/lane_result_buffer.sv
      - design/option_table.sv
      - design/simd_lane_alu.sv
      - design/upstream_sequencer.sv
      - design/simd_wrapper.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/tb_simd_wrapper.sv
